/* hw/csh_macros.svh */
`ifndef CSH_MACROS_SVH
`define CSH_MACROS_SVH

// Cache geometry
`define CSH_WAYS 4

// Diagnostic readback
`define CSH_DIAG_SEL_W 3
`define CSH_DIAG_W 8

`endif

/* hw/cshTypesPkg.sv */
`include "csh_macros.svh"

package cshTypesPkg;

  // Cycle currently owning the sequencer
  typedef enum logic [2:0] {
    CYC_NONE = 3'd0,
    CYC_MB   = 3'd1,
    CYC_CHAN = 3'd2,
    CYC_EBOX = 3'd3,
    CYC_CCA  = 3'd4
  } cycType_e;

  typedef logic [$clog2(`CSH_WAYS)-1:0] wayIdx_t;

  // One bit per way, way 0 in bit 0
  typedef logic [`CSH_WAYS-1:0] wayFlags_t;

endpackage

/* hw/cshDiagPkg.sv */
`include "csh_macros.svh"

package cshDiagPkg;
  import cshTypesPkg::*;

  typedef enum logic [`CSH_DIAG_SEL_W-1:0] {
    DIAG_STATUS = 3'd0,
    DIAG_WAY    = 3'd1,
    DIAG_GRANTS = 3'd2
  } diagSel_e;

  typedef struct packed {
    logic idle;
    logic eboxCyc;
    logic mbCyc;
    logic chanCyc;
    logic ccaCyc;
    logic writebackReq;
    logic coreReadReq;
    logic lastHit;
  } cshStatus_s;

  typedef struct packed {
    wayFlags_t written;
    wayIdx_t   lru;
    wayIdx_t   victim;
  } wayInfo_s;

  // Same byte, decoded per diag select
  typedef union packed {
    logic [`CSH_DIAG_W-1:0] raw;
    cshStatus_s             status;
    wayInfo_s               way;
  } diagByte_u;

endpackage

/* hw/cshIfs.sv */
interface cshSeqIf import cshTypesPkg::*; ();
  logic     start;
  cycType_e cycType;
  logic     t2;
  logic     t3;
  logic     cycDone;
  logic     idle;
  logic     missBusy;

  modport arbiter (output start, cycType, input idle, cycDone);
  modport sequencer (input start, missBusy, output t2, t3, cycDone, idle);
  modport lookup (input t2, cycType);
  modport miss (input t3, output missBusy);
  modport diag (input start, cycType, idle);
endinterface

interface cshLookupIf import cshTypesPkg::*; ();
  logic      resultValid;
  logic      hit;
  wayIdx_t   victim;
  logic      victimWritten;
  wayFlags_t heldWritten;
  // LRU way seen by the last lookup, for diag readback
  wayIdx_t   heldLru;

  modport lookup (output resultValid, hit, victim, victimWritten, heldWritten, heldLru);
  modport miss (input resultValid, hit, victimWritten);
  modport diag (input resultValid, hit, victim, heldWritten, heldLru);
endinterface

/* hw/cshArbiter.sv */
module cshArbiter import cshTypesPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic mbReq,
  input  logic chanReq,
  input  logic eboxReq,
  input  logic ccaReq,
  cshSeqIf.arbiter seq,
  output logic mbGrant,
  output logic chanGrant,
  output logic eboxGrant,
  output logic ccaGrant
);

  logic anyReq;
  logic grantOk;

  assign anyReq = mbReq | chanReq | eboxReq | ccaReq;
  // Idle lags start by a cycle
  assign grantOk = seq.idle & ~seq.start & anyReq;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seq.start   <= 1'b0;
      seq.cycType <= CYC_NONE;
      mbGrant     <= 1'b0;
      chanGrant   <= 1'b0;
      eboxGrant   <= 1'b0;
      ccaGrant    <= 1'b0;
    end else begin
      seq.start <= grantOk;
      mbGrant   <= grantOk & mbReq;
      chanGrant <= grantOk & ~mbReq & chanReq;
      eboxGrant <= grantOk & ~mbReq & ~chanReq & eboxReq;
      ccaGrant  <= grantOk & ~mbReq & ~chanReq & ~eboxReq & ccaReq;
      // Cycle type held until the cycle ends
      if (grantOk) begin
        if (mbReq) seq.cycType <= CYC_MB;
        else if (chanReq) seq.cycType <= CYC_CHAN;
        else if (eboxReq) seq.cycType <= CYC_EBOX;
        else seq.cycType <= CYC_CCA;
      end else if (seq.cycDone) begin
        seq.cycType <= CYC_NONE;
      end
    end
  end

endmodule

/* hw/cshSequencer.sv */
module cshSequencer (
  input logic clk,
  input logic rstN,
  cshSeqIf.sequencer seq
);

  logic t1;

  // Cycle ends in T3 unless a miss holds the chain
  assign seq.cycDone = seq.t3 & ~seq.missBusy;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      t1     <= 1'b0;
      seq.t2 <= 1'b0;
      seq.t3 <= 1'b0;
    end else begin
      t1     <= seq.start;
      seq.t2 <= t1;
      seq.t3 <= seq.t2 | (seq.t3 & seq.missBusy);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seq.idle <= 1'b1;
    end else if (seq.start) begin
      seq.idle <= 1'b0;
    end else if (seq.cycDone) begin
      seq.idle <= 1'b1;
    end
  end

endmodule

/* hw/cshLookup.sv */
`include "csh_macros.svh"

module cshLookup import cshTypesPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  wayFlags_t wayMatch,
  input  wayFlags_t wayWritten,
  input  wayFlags_t wayWordValid,
  input  wayIdx_t   lruWay,
  cshSeqIf.lookup   seq,
  cshLookupIf.lookup lk
);

  logic    ebox2;
  logic    hitNext;
  wayIdx_t victimNext;

  assign ebox2 = seq.t2 & (seq.cycType == CYC_EBOX);
  assign hitNext = |(wayMatch & wayWordValid);

  // Lowest matching way wins, else LRU replacement
  always_comb begin
    victimNext = lruWay;
    for (int i = `CSH_WAYS - 1; i >= 0; i--) begin
      if (wayMatch[i]) victimNext = wayIdx_t'(i);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lk.resultValid   <= 1'b0;
      lk.hit           <= 1'b0;
      lk.victim        <= '0;
      lk.victimWritten <= 1'b0;
      lk.heldWritten   <= '0;
      lk.heldLru       <= '0;
    end else begin
      lk.resultValid <= ebox2;
      if (ebox2) begin
        lk.hit           <= hitNext;
        lk.victim        <= victimNext;
        lk.victimWritten <= wayWritten[victimNext];
        lk.heldWritten   <= wayWritten;
        lk.heldLru       <= lruWay;
      end
    end
  end

endmodule

/* hw/cshMissControl.sv */
module cshMissControl (
  input  logic clk,
  input  logic rstN,
  input  logic coreDone,
  cshSeqIf.miss seq,
  cshLookupIf.miss lk,
  output logic writebackReq,
  output logic coreReadReq,
  output logic eboxResp
);

  typedef enum logic [1:0] {
    MISS_IDLE,
    MISS_WB,
    MISS_CORE_RD,
    MISS_RESP
  } missState_e;

  missState_e state;
  missState_e stateNext;
  logic       missStart;

  assign missStart = seq.t3 & lk.resultValid & ~lk.hit;

  always_comb begin
    stateNext = state;
    case (state)
      MISS_IDLE: begin
        if (missStart) stateNext = lk.victimWritten ? MISS_WB : MISS_CORE_RD;
      end
      MISS_WB: begin
        if (coreDone) stateNext = MISS_CORE_RD;
      end
      MISS_CORE_RD: begin
        if (coreDone) stateNext = MISS_RESP;
      end
      default: stateNext = MISS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= MISS_IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // Requests go out already in T3 of the miss
  assign writebackReq = (state == MISS_WB) | (missStart & lk.victimWritten);
  assign coreReadReq  = (state == MISS_CORE_RD) | (missStart & ~lk.victimWritten);
  assign eboxResp     = (seq.t3 & lk.resultValid & lk.hit) | (state == MISS_RESP);

  // Holds T3 until the refill is in
  assign seq.missBusy = missStart | (state == MISS_WB) | (state == MISS_CORE_RD);

endmodule

/* hw/cshDiagMux.sv */
module cshDiagMux import cshTypesPkg::*, cshDiagPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  diagSel_e  diagSel,
  cshSeqIf.diag     seq,
  cshLookupIf.diag  lk,
  input  logic      writebackReq,
  input  logic      coreReadReq,
  output diagByte_u diagData
);

  logic [7:0] grantCount;
  logic       lastHit;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      grantCount <= '0;
      lastHit    <= 1'b0;
    end else begin
      if (seq.start) grantCount <= grantCount + 8'd1;
      if (lk.resultValid) lastHit <= lk.hit;
    end
  end

  always_comb begin
    diagData.raw = '0;
    case (diagSel)
      DIAG_STATUS: begin
        diagData.status.idle         = seq.idle;
        diagData.status.eboxCyc      = seq.cycType == CYC_EBOX;
        diagData.status.mbCyc        = seq.cycType == CYC_MB;
        diagData.status.chanCyc      = seq.cycType == CYC_CHAN;
        diagData.status.ccaCyc       = seq.cycType == CYC_CCA;
        diagData.status.writebackReq = writebackReq;
        diagData.status.coreReadReq  = coreReadReq;
        diagData.status.lastHit      = lastHit;
      end
      DIAG_WAY: begin
        diagData.way.written = lk.heldWritten;
        diagData.way.lru     = lk.heldLru;
        diagData.way.victim  = lk.victim;
      end
      DIAG_GRANTS: diagData.raw = grantCount;
      default: diagData.raw = '0;
    endcase
  end

endmodule

/* hw/cshTop.sv */
module cshTop import cshTypesPkg::*, cshDiagPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      mbReq,
  input  logic      chanReq,
  input  logic      eboxReq,
  input  logic      ccaReq,
  input  wayFlags_t wayMatch,
  input  wayFlags_t wayWritten,
  input  wayFlags_t wayWordValid,
  input  wayIdx_t   lruWay,
  input  logic      coreDone,
  input  diagSel_e  diagSel,
  output logic      mbGrant,
  output logic      chanGrant,
  output logic      eboxGrant,
  output logic      ccaGrant,
  output cycType_e  cycType,
  output logic      eboxResp,
  output logic      writebackReq,
  output logic      coreReadReq,
  output diagByte_u diagData
);

  cshSeqIf    seqBus ();
  cshLookupIf lkBus ();

  assign cycType = seqBus.cycType;

  cshArbiter uArbiter (
    .clk(clk), .rstN(rstN),
    .mbReq(mbReq), .chanReq(chanReq), .eboxReq(eboxReq), .ccaReq(ccaReq),
    .seq(seqBus),
    .mbGrant(mbGrant), .chanGrant(chanGrant), .eboxGrant(eboxGrant), .ccaGrant(ccaGrant)
  );

  cshSequencer uSequencer (.clk(clk), .rstN(rstN), .seq(seqBus));

  cshLookup uLookup (
    .clk(clk), .rstN(rstN),
    .wayMatch(wayMatch), .wayWritten(wayWritten), .wayWordValid(wayWordValid),
    .lruWay(lruWay), .seq(seqBus), .lk(lkBus)
  );

  cshMissControl uMissControl (
    .clk(clk), .rstN(rstN), .coreDone(coreDone), .seq(seqBus), .lk(lkBus),
    .writebackReq(writebackReq), .coreReadReq(coreReadReq), .eboxResp(eboxResp)
  );

  cshDiagMux uDiagMux (
    .clk(clk), .rstN(rstN), .diagSel(diagSel), .seq(seqBus), .lk(lkBus),
    .writebackReq(writebackReq), .coreReadReq(coreReadReq), .diagData(diagData)
  );

endmodule

/* sim/csh_checker.sv */
module cshChecker import cshTypesPkg::*; (
  input logic     clk,
  input logic     rstN,
  input logic     mbGrant,
  input logic     chanGrant,
  input logic     eboxGrant,
  input logic     ccaGrant,
  input logic     writebackReq,
  input logic     coreReadReq,
  input logic     eboxResp,
  input cycType_e cycType
);
  timeunit 1ns;
  timeprecision 100ps;

  oneGrant: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({mbGrant, chanGrant, eboxGrant, ccaGrant}))
    else $error("more than one grant in a cycle");

  // Writeback and core read are sequential phases
  reqExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(writebackReq && coreReadReq))
    else $error("writeback and core read requested together");

  respInEbox: assert property (@(posedge clk) disable iff (!rstN)
    eboxResp |-> cycType == CYC_EBOX)
    else $error("EBOX response outside an EBOX cycle");
endmodule

bind cshTop cshChecker chk (
  .clk(clk), .rstN(rstN),
  .mbGrant(mbGrant), .chanGrant(chanGrant), .eboxGrant(eboxGrant), .ccaGrant(ccaGrant),
  .writebackReq(writebackReq), .coreReadReq(coreReadReq), .eboxResp(eboxResp),
  .cycType(cycType)
);

/* sim/cshTb.sv */
module cshTb import cshTypesPkg::*, cshDiagPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumTrans = 400;
  // Worst case transaction is about 30 cycles
  localparam int MaxCycles = NumTrans * 30;

  logic      clk;
  logic      rstN;
  logic      mbReq;
  logic      chanReq;
  logic      eboxReq;
  logic      ccaReq;
  wayFlags_t wayMatch;
  wayFlags_t wayWritten;
  wayFlags_t wayWordValid;
  wayIdx_t   lruWay;
  logic      coreDone;
  diagSel_e  diagSel;
  logic      mbGrant;
  logic      chanGrant;
  logic      eboxGrant;
  logic      ccaGrant;
  cycType_e  cycType;
  logic      eboxResp;
  logic      writebackReq;
  logic      coreReadReq;
  diagByte_u diagData;

  // Reference model state
  logic [3:0]  pend;
  logic [7:0]  grantCnt;
  logic        lastHit;
  logic        idleM;
  wayFlags_t   heldWritten;
  wayIdx_t     heldLru;
  wayIdx_t     victim;
  logic [31:0] lfsr;
  int          cycles;

  cshTop dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [7:0] rnd(input int n);
    logic [7:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[6:0], fb};
    end
    return v;
  endfunction

  // Bits are MB, channel, EBOX, CCA from the top
  function automatic logic [3:0] pick(input logic [3:0] p);
    if (p[3]) return 4'b1000;
    if (p[2]) return 4'b0100;
    if (p[1]) return 4'b0010;
    if (p[0]) return 4'b0001;
    return 4'b0000;
  endfunction

  function automatic cycType_e typeOf(input logic [3:0] g);
    if (g[3]) return CYC_MB;
    if (g[2]) return CYC_CHAN;
    if (g[1]) return CYC_EBOX;
    if (g[0]) return CYC_CCA;
    return CYC_NONE;
  endfunction

  function automatic diagByte_u diagModel(input cycType_e t, input logic wb, input logic cr);
    diagByte_u d;
    d.raw = '0;
    if (diagSel == DIAG_STATUS) begin
      d.status = '{idleM, t == CYC_EBOX, t == CYC_MB, t == CYC_CHAN, t == CYC_CCA,
                   wb, cr, lastHit};
    end else if (diagSel == DIAG_WAY) begin
      d.way = '{heldWritten, heldLru, victim};
    end else if (diagSel == DIAG_GRANTS) begin
      d.raw = grantCnt;
    end
    return d;
  endfunction

  task automatic reportMismatch(input string name, input logic [7:0] act, input logic [7:0] exp);
    $display("ERR %0t %s got %0h expected %0h", $time, name, act, exp);
    $display("Finished with errors");
    $fatal(1, "value mismatch");
  endtask

  task automatic checkFlag(input string name, input logic act, input logic exp);
    if (act !== exp) reportMismatch(name, act, exp);
  endtask

  task automatic checkCycType(input string name, input cycType_e act, input cycType_e exp);
    if (act !== exp) reportMismatch(name, act, exp);
  endtask

  task automatic checkDiag(input string name, input diagByte_u act, input diagByte_u exp);
    if (act.raw !== exp.raw) reportMismatch(name, act.raw, exp.raw);
  endtask

  task automatic step(input logic cd);
    @(posedge clk);
    cycles++;
    if (cycles > MaxCycles) begin
      $display("Timeout: no end of test after %0d cycles", MaxCycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
    diagSel  <= diagSel_e'(3'(rnd(3)));
    coreDone <= cd;
    {mbReq, chanReq, eboxReq, ccaReq} <= pend;
  endtask

  task automatic expectCycle(input logic [3:0] g, input cycType_e t, input logic wb,
                             input logic cr, input logic resp);
    @(negedge clk);
    checkFlag("mbGrant", mbGrant, g[3]);
    checkFlag("chanGrant", chanGrant, g[2]);
    checkFlag("eboxGrant", eboxGrant, g[1]);
    checkFlag("ccaGrant", ccaGrant, g[0]);
    checkCycType("cycType", cycType, t);
    checkFlag("writebackReq", writebackReq, wb);
    checkFlag("coreReadReq", coreReadReq, cr);
    checkFlag("eboxResp", eboxResp, resp);
    checkDiag("diagData", diagData, diagModel(t, wb, cr));
  endtask

  // Request stays up until coreDone 1 to 8 cycles later
  task automatic refillPhase(input logic wb);
    int d;
    d = rnd(3) + 1;
    for (int k = 1; k <= d; k++) begin
      step(k == d);
      expectCycle(4'b0, CYC_EBOX, wb, !wb, 1'b0);
    end
  endtask

  initial begin
    logic [3:0] g;
    cycType_e   t;
    logic       hit;
    logic       vw;
    logic       miss;
    logic       found;
    rstN = 1'b0;
    {mbReq, chanReq, eboxReq, ccaReq} = '0;
    wayMatch = '0;
    wayWritten = '0;
    wayWordValid = '0;
    lruWay = '0;
    coreDone = 1'b0;
    diagSel = DIAG_STATUS;
    lfsr = 32'h5c6a7048;
    pend = '0;
    grantCnt = '0;
    lastHit = 1'b0;
    idleM = 1'b1;
    heldWritten = '0;
    heldLru = '0;
    victim = '0;
    cycles = 0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    for (int n = 0; n < NumTrans; n++) begin
      g = '0;
      while (g == 4'b0) begin
        g = pick(pend);
        if (g != 4'b0) pend = pend & ~g;
        else pend = pend | 4'(rnd(4) & rnd(4));
        // Stray coreDone while idle must be ignored
        step(g == 4'b0 ? 1'(rnd(1)) : 1'b0);
        expectCycle(g, typeOf(g), 1'b0, 1'b0, 1'b0);
      end
      t = typeOf(g);

      step(1'b0);
      grantCnt++;
      idleM = 1'b0;
      wayMatch     <= wayFlags_t'(rnd(4) & rnd(4));
      wayWritten   <= wayFlags_t'(rnd(4));
      wayWordValid <= wayFlags_t'(rnd(4));
      lruWay       <= wayIdx_t'(rnd(2));
      expectCycle(4'b0, t, 1'b0, 1'b0, 1'b0);
      step(1'b0);
      expectCycle(4'b0, t, 1'b0, 1'b0, 1'b0);

      // T3 lookup result
      hit = 1'b0;
      vw = 1'b0;
      if (t == CYC_EBOX) begin
        found = 1'b0;
        victim = lruWay;
        for (int i = 0; i < 4; i++) begin
          if (wayMatch[i] && wayWordValid[i]) hit = 1'b1;
          if (wayMatch[i] && !found) begin
            victim = wayIdx_t'(i);
            found = 1'b1;
          end
        end
        vw = wayWritten[victim];
        heldWritten = wayWritten;
        heldLru = lruWay;
      end
      miss = (t == CYC_EBOX) && !hit;
      step(1'b0);
      expectCycle(4'b0, t, miss && vw, miss && !vw, (t == CYC_EBOX) && hit);
      if (t == CYC_EBOX) lastHit = hit;

      if (miss) begin
        if (vw) begin
          refillPhase(1'b1);
          step(1'b0);
          expectCycle(4'b0, CYC_EBOX, 1'b0, 1'b1, 1'b0);
        end
        refillPhase(1'b0);
        step(1'b0);
        expectCycle(4'b0, CYC_EBOX, 1'b0, 1'b0, 1'b1);
      end

      step(1'b0);
      idleM = 1'b1;
      expectCycle(4'b0, CYC_NONE, 1'b0, 1'b0, 1'b0);
    end

    $display("Finished with no errors");
    $finish;
  end
endmodule

/* compile.f */
+incdir+hw
hw/cshTypesPkg.sv
hw/cshDiagPkg.sv
hw/cshIfs.sv
hw/cshArbiter.sv
hw/cshSequencer.sv
hw/cshLookup.sv
hw/cshMissControl.sv
hw/cshDiagMux.sv
hw/cshTop.sv
sim/csh_checker.sv
sim/cshTb.sv

/* Makefile */
TOP       ?= cshTb
SEED      ?= 0
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD     ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG) || ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
